/* all.f */
+incdir+tb
logic/fme_pkg.sv
logic/fme_candi_gen.sv
logic/fme_pred.sv
logic/pred_buf_arb.sv
logic/pred_buf_mem.sv
logic/pred_rd_port.sv
logic/fme_top.sv
tb/fme_tb.sv

/* logic/fme_candi_gen.sv */
// quarter-pel candidate generator
module fme_candi_gen (
	input  logic                clk,
	input  logic                rstn,
	input  logic                blk_start_i,   // block start strobe
	input  fme_pkg::frac_t      frac_x_i,      // half-pel center x
	input  fme_pkg::frac_t      frac_y_i,      // half-pel center y
	input  logic                win_valid_i,   // window row strobe
	input  fme_pkg::win_row_t   win_row_i,
	output fme_pkg::candi_set_t candi_o,
	output logic                blk_end_o      // last block row out
);

	// ******************************
	// 2x2 bilinear kernel
	// ******************************
	function automatic fme_pkg::row_t interp_row(
		input fme_pkg::win_row_t top,   // upper source row
		input fme_pkg::win_row_t bot,   // lower source row
		input logic [1:0]        fx,    // x weight, 0..3
		input logic [1:0]        fy,    // y weight, 0..3
		input logic              left   // x base is -1
	);
		fme_pkg::row_t   res;
		fme_pkg::pixel_t p00;
		fme_pkg::pixel_t p01;
		fme_pkg::pixel_t p10;
		fme_pkg::pixel_t p11;
		logic [2:0]      wx0;
		logic [2:0]      wx1;
		logic [2:0]      wy0;
		logic [2:0]      wy1;
		logic [3:0]      col;
		logic [11:0]     acc;           // 16*255 + 8 fits
		res = '0;
		wx1 = {1'b0, fx};
		wx0 = 3'd4 - wx1;
		wy1 = {1'b0, fy};
		wy0 = 3'd4 - wy1;
		for (int c = 0; c < fme_pkg::BLK_ROWS; c++) begin
			col = 4'(c) + {3'b000, ~left};   // window column c+1+base
			p00 = top[col*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH];
			p01 = top[(col+4'd1)*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH];
			p10 = bot[col*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH];
			p11 = bot[(col+4'd1)*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH];
			acc = wx0*wy0*p00 + wx1*wy0*p01 + wx0*wy1*p10 + wx1*wy1*p11 + 12'd8;
			res[c*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH] = acc[11:4];  // round, /16
		end
		return res;
	endfunction

	fme_pkg::win_row_t                      prev1_q;    // window row k-1
	fme_pkg::win_row_t                      prev2_q;    // window row k-2
	fme_pkg::frac_t                         frac_x_q;
	fme_pkg::frac_t                         frac_y_q;
	logic [3:0]                             row_cnt_q;  // window rows seen
	fme_pkg::row_t [fme_pkg::NUM_CANDI-1:0] candi_d;
	fme_pkg::row_t [fme_pkg::NUM_CANDI-1:0] candi_q;
	logic                                   valid_q;
	logic                                   end_q;

	// ******************************
	// nine candidates
	// ******************************
	// the low two bits of q are the weight for both signs (q+4 mod 4)
	always_comb begin
		logic signed [3:0] qx;
		logic signed [3:0] qy;
		for (int i = 0; i < fme_pkg::NUM_CANDI; i++) begin
			qx = 4'(frac_x_q + i % 3 - 1);   // quarter offset x
			qy = 4'(frac_y_q + i / 3 - 1);   // quarter offset y
			candi_d[i] = interp_row(qy[3] ? prev2_q : prev1_q,
				qy[3] ? prev1_q : win_row_i,
				qx[1:0], qy[1:0], qx[3]);
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			frac_x_q  <= '0;
			frac_y_q  <= '0;
			row_cnt_q <= '0;
		end else if (blk_start_i) begin
			frac_x_q  <= frac_x_i;               // center of the new block
			frac_y_q  <= frac_y_i;
			row_cnt_q <= '0;
		end else if (win_valid_i) begin
			row_cnt_q <= row_cnt_q + 4'd1;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			valid_q <= 1'b0;
			end_q   <= 1'b0;
		end else begin
			valid_q <= win_valid_i && (row_cnt_q >= 4'd2);   // rows 2..9 give output
			end_q   <= win_valid_i && (row_cnt_q == 4'(fme_pkg::WIN_ROWS - 1));
		end
	end

	// row line buffer and candidate payload
	always_ff @(posedge clk) begin
		if (win_valid_i) begin
			prev2_q <= prev1_q;
			prev1_q <= win_row_i;
			candi_q <= candi_d;
		end
	end

	assign candi_o.row   = candi_q;
	assign candi_o.valid = valid_q;
	assign blk_end_o     = end_q;

endmodule

/* logic/fme_pkg.sv */
// fme prediction shared types
package fme_pkg;

	// ******************************
	// sizes
	// ******************************
	localparam int PIXEL_WIDTH = 8;                 // bits per luma sample
	localparam int FMV_WIDTH   = 8;                 // quarter-pel mv component
	localparam int WIN_ROWS    = 10;                // window rows per block
	localparam int BLK_ROWS    = 8;                 // predicted rows per block
	localparam int NUM_CANDI   = 9;                 // 3x3 quarter-pel grid
	localparam int NUM_BANKS   = 4;                 // banks per buffer line

	typedef logic        [PIXEL_WIDTH-1:0] pixel_t;
	typedef logic signed [FMV_WIDTH-1:0]   mv_t;          // quarter-pel units
	typedef logic signed [2:0]             frac_t;        // -2, 0 or +2
	typedef logic        [3:0]             candi_idx_t;   // 0..8 row-major
	typedef logic        [5:0]             blk_idx_t;     // {cnt32, cnt16, cnt08}, y above x
	typedef logic        [6:0]             pred_addr_t;   // {c32y, c32x, c16y, c08y, row}

	// pixel 0 sits in the low bits of a row
	typedef logic [BLK_ROWS*PIXEL_WIDTH-1:0]           row_t;
	typedef logic [WIN_ROWS*PIXEL_WIDTH-1:0]           win_row_t;
	typedef logic [NUM_BANKS*BLK_ROWS*PIXEL_WIDTH-1:0] line_t;  // bank 3 on top

	typedef struct packed {
		mv_t      imv_x;
		mv_t      imv_y;
		mv_t      fmv_x;
		mv_t      fmv_y;
		blk_idx_t blk_idx;
	} blk_desc_t;

	typedef struct packed {
		row_t [NUM_CANDI-1:0] row;   // row[i] is candidate i
		logic                 valid;
	} candi_set_t;

	typedef struct packed {
		logic [NUM_BANKS-1:0] wren;  // one bit per bank
		pred_addr_t           addr;
		line_t                data;
	} buf_wr_t;

	typedef struct packed {
		logic       req;
		pred_addr_t addr;
	} buf_rd_t;

endpackage

/* logic/fme_pred.sv */
// best-candidate predictor and buffer write steering
module fme_pred (
	input  logic                clk,
	input  logic                rstn,
	input  logic                blk_start_i,   // descriptor strobe
	input  fme_pkg::blk_desc_t  blk_desc_i,
	output fme_pkg::frac_t      frac_x_o,      // to candidate generator
	output fme_pkg::frac_t      frac_y_o,
	input  fme_pkg::candi_set_t candi_i,
	input  logic                blk_end_i,     // block's last row
	output fme_pkg::buf_wr_t    buf_wr_o
);

	fme_pkg::mv_t        dmv_x;
	fme_pkg::mv_t        dmv_y;
	fme_pkg::mv_t        off_x;         // dmv around center, -1..1
	fme_pkg::mv_t        off_y;
	fme_pkg::candi_idx_t best_d;
	fme_pkg::candi_idx_t best_q [2];    // ping-pong best index
	fme_pkg::blk_idx_t   idx_q [2];     // ping-pong block index
	logic                wr_ptr_q;
	logic                rd_ptr_q;
	fme_pkg::candi_idx_t best_rd;
	fme_pkg::blk_idx_t   idx_rd;
	logic [2:0]          row_cnt_q;
	logic [1:0]          bank;
	fme_pkg::row_t       sel_row;

	// ******************************
	// descriptor decode
	// ******************************
	assign dmv_x = blk_desc_i.fmv_x - blk_desc_i.imv_x;
	assign dmv_y = blk_desc_i.fmv_y - blk_desc_i.imv_y;

	assign frac_x_o = (dmv_x == 0) ? 3'sd0 : ((dmv_x < 0) ? -3'sd2 : 3'sd2);
	assign frac_y_o = (dmv_y == 0) ? 3'sd0 : ((dmv_y < 0) ? -3'sd2 : 3'sd2);

	assign off_x  = dmv_x - frac_x_o;
	assign off_y  = dmv_y - frac_y_o;
	assign best_d = fme_pkg::candi_idx_t'((off_y + 8'sd1) * 8'sd3 + off_x + 8'sd1);

	// write side follows starts, read side follows ends
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr_q <= 1'b0;
			best_q   <= '{default: '0};
			idx_q    <= '{default: '0};
		end else if (blk_start_i) begin
			wr_ptr_q         <= ~wr_ptr_q;
			best_q[wr_ptr_q] <= best_d;
			idx_q[wr_ptr_q]  <= blk_desc_i.blk_idx;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rd_ptr_q <= 1'b0;
		end else if (blk_end_i) begin
			rd_ptr_q <= ~rd_ptr_q;               // next block in completion order
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			row_cnt_q <= '0;
		end else if (candi_i.valid) begin
			row_cnt_q <= (row_cnt_q == 3'(fme_pkg::BLK_ROWS - 1)) ? 3'd0 : row_cnt_q + 3'd1;
		end
	end

	// ******************************
	// row select and bank steering
	// ******************************
	assign best_rd = best_q[rd_ptr_q];
	assign idx_rd  = idx_q[rd_ptr_q];
	assign sel_row = (best_rd < 4'(fme_pkg::NUM_CANDI)) ? candi_i.row[best_rd] : candi_i.row[4];
	assign bank    = 2'd3 - {idx_rd[2], idx_rd[0]};   // {cnt16 x, cnt08 x}

	always_comb begin
		buf_wr_o.wren = '0;
		buf_wr_o.data = '0;
		buf_wr_o.addr = {idx_rd[5], idx_rd[4], idx_rd[3], idx_rd[1], row_cnt_q};
		buf_wr_o.data[bank*$bits(fme_pkg::row_t) +: $bits(fme_pkg::row_t)] = sel_row;
		buf_wr_o.wren[bank] = candi_i.valid;      // one-hot, only on valid rows
	end

endmodule

/* logic/fme_top.sv */
// fme prediction back end top
module fme_top (
	input  logic                clk,
	input  logic                rstn,
	input  logic                blk_start_i,   // block start strobe
	input  fme_pkg::blk_desc_t  blk_desc_i,    // sampled on blk_start_i
	input  logic                win_valid_i,
	input  fme_pkg::win_row_t   win_row_i,
	input  logic                rd_req_i,      // four-phase read
	input  fme_pkg::pred_addr_t rd_addr_i,
	output logic                rd_ack_o,
	output fme_pkg::line_t      rd_data_o
);

	fme_pkg::frac_t      frac_x;
	fme_pkg::frac_t      frac_y;
	fme_pkg::candi_set_t candi;        // nine rows + valid
	logic                blk_end;
	fme_pkg::buf_wr_t    buf_wr;       // predictor write
	fme_pkg::buf_wr_t    mem_wr;       // write into memory
	fme_pkg::buf_rd_t    buf_rd;
	logic                rd_gnt;
	logic                mem_rd_en;
	fme_pkg::pred_addr_t mem_rd_addr;
	fme_pkg::line_t      mem_data;

	// ******************************
	// prediction path
	// ******************************
	fme_candi_gen candi_gen0 (
		.clk         (clk),
		.rstn        (rstn),
		.blk_start_i (blk_start_i),
		.frac_x_i    (frac_x),
		.frac_y_i    (frac_y),
		.win_valid_i (win_valid_i),
		.win_row_i   (win_row_i),
		.candi_o     (candi),
		.blk_end_o   (blk_end)
	);

	fme_pred pred0 (
		.clk         (clk),
		.rstn        (rstn),
		.blk_start_i (blk_start_i),
		.blk_desc_i  (blk_desc_i),
		.frac_x_o    (frac_x),
		.frac_y_o    (frac_y),
		.candi_i     (candi),
		.blk_end_i   (blk_end),
		.buf_wr_o    (buf_wr)
	);

	// ******************************
	// buffer and read side
	// ******************************
	pred_buf_arb arb0 (
		.clk           (clk),
		.rstn          (rstn),
		.wr_i          (buf_wr),
		.rd_i          (buf_rd),
		.rd_gnt_o      (rd_gnt),
		.mem_wr_o      (mem_wr),
		.mem_rd_en_o   (mem_rd_en),
		.mem_rd_addr_o (mem_rd_addr)
	);

	pred_buf_mem mem0 (
		.clk       (clk),
		.wr_i      (mem_wr),
		.rd_en_i   (mem_rd_en),
		.rd_addr_i (mem_rd_addr),
		.rd_data_o (mem_data)
	);

	pred_rd_port rd_port0 (
		.clk        (clk),
		.rstn       (rstn),
		.rd_req_i   (rd_req_i),
		.rd_addr_i  (rd_addr_i),
		.rd_ack_o   (rd_ack_o),
		.rd_data_o  (rd_data_o),
		.buf_rd_o   (buf_rd),
		.rd_gnt_i   (rd_gnt),
		.mem_data_i (mem_data)
	);

endmodule

/* logic/pred_buf_arb.sv */
// prediction buffer arbiter
module pred_buf_arb (
	input  logic                clk,
	input  logic                rstn,
	input  fme_pkg::buf_wr_t    wr_i,            // from predictor
	input  fme_pkg::buf_rd_t    rd_i,            // from read port
	output logic                rd_gnt_o,        // read data valid this cycle
	output fme_pkg::buf_wr_t    mem_wr_o,
	output logic                mem_rd_en_o,
	output fme_pkg::pred_addr_t mem_rd_addr_o
);

	logic wr_busy;   // any bank written now
	logic gnt_q;

	// writer always wins, never stalled
	assign wr_busy       = |wr_i.wren;
	assign mem_wr_o      = wr_i;
	assign mem_rd_en_o   = rd_i.req & ~wr_busy;   // read only in a free cycle
	assign mem_rd_addr_o = rd_i.addr;

	// ******************************
	// grant aligned with read data
	// ******************************
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			gnt_q <= 1'b0;
		end else begin
			gnt_q <= mem_rd_en_o;
		end
	end

	assign rd_gnt_o = gnt_q;

endmodule

/* logic/pred_buf_mem.sv */
// four-bank prediction buffer
module pred_buf_mem (
	input  logic                clk,
	input  fme_pkg::buf_wr_t    wr_i,        // per-bank write enables
	input  logic                rd_en_i,
	input  fme_pkg::pred_addr_t rd_addr_i,
	output fme_pkg::line_t      rd_data_o    // one cycle after rd_en_i
);

	// power-up contents are zero
	fme_pkg::row_t bank_mem [fme_pkg::NUM_BANKS][2**$bits(fme_pkg::pred_addr_t)] =
		'{default: '0};
	fme_pkg::line_t rd_data_q;

	// ******************************
	// bank writes
	// ******************************
	always_ff @(posedge clk) begin
		for (int b = 0; b < fme_pkg::NUM_BANKS; b++) begin
			if (wr_i.wren[b]) begin
				bank_mem[b][wr_i.addr] <= wr_i.data[b*$bits(fme_pkg::row_t) +: $bits(fme_pkg::row_t)];
			end
		end
	end

	// full line read, all banks at once
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			for (int b = 0; b < fme_pkg::NUM_BANKS; b++) begin
				rd_data_q[b*$bits(fme_pkg::row_t) +: $bits(fme_pkg::row_t)] <= bank_mem[b][rd_addr_i];
			end
		end
	end

	assign rd_data_o = rd_data_q;

endmodule

/* logic/pred_rd_port.sv */
// four-phase read port
module pred_rd_port (
	input  logic                clk,
	input  logic                rstn,
	input  logic                rd_req_i,     // from external master
	input  fme_pkg::pred_addr_t rd_addr_i,    // stable while req high
	output logic                rd_ack_o,
	output fme_pkg::line_t      rd_data_o,
	output fme_pkg::buf_rd_t    buf_rd_o,     // toward arbiter
	input  logic                rd_gnt_i,     // data valid on mem_data_i
	input  fme_pkg::line_t      mem_data_i
);

	typedef enum logic [2:0] {
		RD_IDLE,
		RD_REQ,          // request issued this cycle
		RD_WAIT_DATA,    // grant or retry
		RD_ACK,          // line held, ack high
		RD_RELEASE       // ack low, wait req low
	} rd_state_e;

	rd_state_e           state_q;
	rd_state_e           state_d;
	fme_pkg::pred_addr_t addr_q;
	fme_pkg::line_t      data_q;

	// ******************************
	// handshake FSM
	// ******************************
	always_comb begin
		state_d = state_q;
		case (state_q)
			RD_IDLE: begin
				if (rd_req_i) state_d = RD_REQ;
			end
			RD_REQ: begin
				state_d = RD_WAIT_DATA;
			end
			RD_WAIT_DATA: begin
				state_d = rd_gnt_i ? RD_ACK : RD_REQ;   // lost to a write, try again
			end
			RD_ACK: begin
				if (!rd_req_i) state_d = RD_RELEASE;
			end
			RD_RELEASE: begin
				if (!rd_req_i) state_d = RD_IDLE;
			end
			default: begin
				state_d = RD_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= RD_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// address and line capture
	always_ff @(posedge clk) begin
		if (state_q == RD_IDLE && rd_req_i) begin
			addr_q <= rd_addr_i;
		end
		if (state_q == RD_WAIT_DATA && rd_gnt_i) begin
			data_q <= mem_data_i;
		end
	end

	assign buf_rd_o.req  = (state_q == RD_REQ);
	assign buf_rd_o.addr = addr_q;
	assign rd_ack_o      = (state_q == RD_ACK);
	assign rd_data_o     = data_q;

endmodule

/* tb/fme_ref.svh */
// fme reference models
`ifndef FME_REF_SVH
`define FME_REF_SVH

// one 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// half-pel center from the mv difference
function automatic int ref_frac(input int dmv);
	if (dmv == 0) return 0;
	return (dmv < 0) ? -2 : 2;
endfunction

function automatic int ref_best(input int dmv_x, input int dmv_y);
	return (dmv_y - ref_frac(dmv_y) + 1) * 3 + (dmv_x - ref_frac(dmv_x)) + 1;
endfunction

// integer base and weight of a quarter offset
function automatic int ref_base(input int q);
	return (q < 0) ? -1 : 0;
endfunction

function automatic int ref_weight(input int q);
	return (q < 0) ? q + 4 : q;
endfunction

// 2x2 bilinear mix, col is the left source column
function automatic fme_pkg::pixel_t ref_pixel(
	input fme_pkg::win_row_t top,
	input fme_pkg::win_row_t bot,
	input int                col,
	input int                fx,
	input int                fy
);
	int p00;
	int p01;
	int p10;
	int p11;
	int acc;
	p00 = top[col*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH];
	p01 = top[(col+1)*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH];
	p10 = bot[col*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH];
	p11 = bot[(col+1)*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH];
	acc = (4-fx)*(4-fy)*p00 + fx*(4-fy)*p01 + (4-fx)*fy*p10 + fx*fy*p11 + 8;
	return fme_pkg::pixel_t'(acc >> 4);   // round, /16
endfunction

// buffer line of one block row
function automatic fme_pkg::pred_addr_t ref_addr(input fme_pkg::blk_idx_t idx, input int row);
	return {idx[5], idx[4], idx[3], idx[1], 3'(row)};
endfunction

function automatic int ref_bank(input fme_pkg::blk_idx_t idx);
	return 3 - (2 * idx[2] + idx[0]);     // {cnt16 x, cnt08 x}
endfunction

`endif

/* tb/fme_tb.sv */
// fme prediction back end testbench
module fme_tb;

	`include "fme_ref.svh"

	localparam int NUM_BLOCKS      = 68;    // 4 still + 60 random + 4 overlapped
	localparam int NUM_READS       = 187;
	localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 12 + NUM_READS * 8 + 50;
	localparam int ACK_LIMIT       = 64;    // cycles one handshake phase may take
	localparam int NUM_LINES       = 2**$bits(fme_pkg::pred_addr_t);

	logic                clk;
	logic                rstn;
	logic                blk_start;
	fme_pkg::blk_desc_t  blk_desc;
	logic                win_valid;
	fme_pkg::win_row_t   win_row;
	logic                rd_req;
	fme_pkg::pred_addr_t rd_addr;
	logic                rd_ack;
	fme_pkg::line_t      rd_data;

	logic [31:0]         rng_state = 32'd26873;
	fme_pkg::win_row_t   win_buf [fme_pkg::WIN_ROWS];   // window of the next block
	fme_pkg::line_t      model_mem [NUM_LINES] = '{default: '0};
	fme_pkg::line_t      got_q [$];
	fme_pkg::line_t      exp_q [$];
	fme_pkg::pred_addr_t addr_q [$];
	int                  line_errs = 0;
	int                  bit_errs = 0;
	int                  proto_errs = 0;

	fme_top dut0 (
		.clk         (clk),
		.rstn        (rstn),
		.blk_start_i (blk_start),
		.blk_desc_i  (blk_desc),
		.win_valid_i (win_valid),
		.win_row_i   (win_row),
		.rd_req_i    (rd_req),
		.rd_addr_i   (rd_addr),
		.rd_ack_o    (rd_ack),
		.rd_data_o   (rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ******************************
	// checks
	// ******************************
	task automatic check_line(input string name, input fme_pkg::pred_addr_t addr,
		input fme_pkg::line_t got, input fme_pkg::line_t exp);
		if (got !== exp) begin
			line_errs++;
			$display("Fail %s at line %h: got %h expected %h", name, addr, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			bit_errs++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	// read-back compare, one line per returned handshake
	initial begin
		forever begin
			@(negedge clk);
			while (got_q.size() > 0) begin
				check_line("rd_data_o", addr_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
			end
		end
	end

	// ******************************
	// stimulus helpers
	// ******************************
	function automatic logic [31:0] rand32();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic fill_window();
		logic [31:0] r;
		for (int y = 0; y < fme_pkg::WIN_ROWS; y++) begin
			for (int x = 0; x < $bits(fme_pkg::win_row_t) / fme_pkg::PIXEL_WIDTH; x++) begin
				r = rand32();
				win_buf[y][x*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH] = r[7:0];
			end
		end
	endtask

	function automatic fme_pkg::blk_desc_t make_desc(input fme_pkg::blk_idx_t idx,
		input logic still);
		fme_pkg::blk_desc_t d;
		int dx;
		int dy;
		d.imv_x = fme_pkg::mv_t'(rand32());
		d.imv_y = fme_pkg::mv_t'(rand32());
		dx = still ? 0 : int'(rand32() % 7) - 3;   // dmv -3..3
		dy = still ? 0 : int'(rand32() % 7) - 3;
		d.fmv_x = fme_pkg::mv_t'(d.imv_x + dx);
		d.fmv_y = fme_pkg::mv_t'(d.imv_y + dy);
		d.blk_idx = idx;
		return d;
	endfunction

	// expected buffer contents after one block
	task automatic model_block(input fme_pkg::blk_desc_t d);
		fme_pkg::mv_t        dmv_x;
		fme_pkg::mv_t        dmv_y;
		int                  best;
		int                  qx;
		int                  qy;
		fme_pkg::row_t       row;
		fme_pkg::pred_addr_t addr;
		dmv_x = d.fmv_x - d.imv_x;
		dmv_y = d.fmv_y - d.imv_y;
		best = ref_best(dmv_x, dmv_y);
		qx = ref_frac(dmv_x) + best % 3 - 1;
		qy = ref_frac(dmv_y) + best / 3 - 1;
		for (int r = 0; r < fme_pkg::BLK_ROWS; r++) begin
			for (int c = 0; c < fme_pkg::BLK_ROWS; c++) begin
				row[c*fme_pkg::PIXEL_WIDTH +: fme_pkg::PIXEL_WIDTH] =
					ref_pixel(win_buf[r+1+ref_base(qy)], win_buf[r+2+ref_base(qy)],
						c+1+ref_base(qx), ref_weight(qx), ref_weight(qy));
			end
			addr = ref_addr(d.blk_idx, r);
			model_mem[addr][ref_bank(d.blk_idx)*$bits(fme_pkg::row_t) +: $bits(fme_pkg::row_t)] = row;
		end
	endtask

	// start strobe then ten rows, win_valid left high for a back-to-back start
	task automatic send_block(input fme_pkg::blk_desc_t d, input logic gaps);
		model_block(d);
		@(posedge clk);
		blk_start <= 1'b1;
		blk_desc  <= d;
		win_valid <= 1'b0;
		for (int r = 0; r < fme_pkg::WIN_ROWS; r++) begin
			@(posedge clk);
			blk_start <= 1'b0;
			win_valid <= 1'b1;
			win_row   <= win_buf[r];
			if (gaps && r < fme_pkg::WIN_ROWS - 1 && (rand32() & 32'h7) == 0) begin
				@(posedge clk);
				win_valid <= 1'b0;   // one idle cycle between rows
			end
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		blk_start <= 1'b0;
		win_valid <= 1'b0;
	endtask

	// four-phase master, lat counts sampled cycles until ack
	task automatic read_line(input fme_pkg::pred_addr_t addr, output int lat);
		int waited;
		addr_q.push_back(addr);
		exp_q.push_back(model_mem[addr]);
		@(posedge clk);
		rd_req  <= 1'b1;
		rd_addr <= addr;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!rd_ack && waited < ACK_LIMIT);
		lat = waited;
		if (!rd_ack) begin
			proto_errs++;
			addr_q.pop_back();
			exp_q.pop_back();
			$display("Read of line %h got no ack within %0d cycles", addr, ACK_LIMIT);
		end else begin
			got_q.push_back(rd_data);
		end
		check_bit("rd_ack_o after two cycles", waited >= 3, 1'b1);
		@(posedge clk);
		rd_req <= 1'b0;
		@(negedge clk);
		check_bit("rd_ack_o", rd_ack, 1'b1);   // still high, req seen low next edge
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (rd_ack && waited < ACK_LIMIT);
		check_bit("rd_ack_o", rd_ack, 1'b0);
	endtask

	// ******************************
	// test sequence
	// ******************************
	initial begin
		int                lat;
		fme_pkg::blk_idx_t ovr [4];   // blocks written again under reads
		rstn      = 1'b0;
		blk_start = 1'b0;
		blk_desc  = '0;
		win_valid = 1'b0;
		win_row   = '0;
		rd_req    = 1'b0;
		rd_addr   = '0;
		repeat (2) @(posedge clk);
		rstn <= 1'b1;

		// empty buffer after reset
		@(negedge clk);
		check_bit("rd_ack_o", rd_ack, 1'b0);
		read_line(7'd0, lat);
		read_line(7'd127, lat);
		read_line(fme_pkg::pred_addr_t'(rand32()), lat);

		// zero dmv, back to back
		for (int b = 0; b < 4; b++) begin
			fill_window();
			send_block(make_desc(fme_pkg::blk_idx_t'(b), 1'b1), 1'b0);
		end
		idle_cycle();
		for (int a = 0; a < 16; a++) begin
			read_line(fme_pkg::pred_addr_t'(a), lat);
		end

		// remaining indices with random dmv and row gaps
		for (int b = 4; b < 64; b++) begin
			fill_window();
			send_block(make_desc(fme_pkg::blk_idx_t'(b), 1'b0), 1'b1);
		end
		idle_cycle();
		for (int a = 0; a < NUM_LINES; a++) begin
			read_line(fme_pkg::pred_addr_t'(a), lat);
		end

		// reads of other lines while a block streams
		for (int i = 0; i < 4; i++) begin
			ovr[i] = fme_pkg::blk_idx_t'(rand32());
			fill_window();
			fork
				begin
					send_block(make_desc(ovr[i], 1'b0), 1'b0);
					idle_cycle();
				end
				begin
					repeat (5) @(posedge clk);   // land inside the write burst
					read_line(ref_addr(ovr[i] ^ 6'h20, 0), lat);
					check_bit("rd_ack_o delayed by writes", lat > 4, 1'b1);
					read_line(ref_addr(ovr[i] ^ 6'h20, 5), lat);
				end
			join
		end
		idle_cycle();
		for (int i = 0; i < 4; i++) begin
			for (int r = 0; r < fme_pkg::BLK_ROWS; r++) begin
				read_line(ref_addr(ovr[i], r), lat);
			end
		end

		@(negedge clk);
		@(negedge clk);
		$display("errors: %0d line, %0d bit, %0d protocol", line_errs, bit_errs, proto_errs);
		if (line_errs + bit_errs + proto_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule
